//--- rvPipe.f
+incdir+src
src/rvPipePkg.sv
src/pipelineRegisters.sv
src/decodeStage.sv
src/hazardUnit.sv
src/executeStage.sv
src/rvPipeCore.sv
tests/tbClock.sv
tests/rvPipeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rvPipe.f \
    --top-module rvPipeTb \
    -o rvPipeSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/rvPipeSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

//--- tests/rvPipeTb.sv
// Directed tests for the five-stage core against an in-order reference model
// Instruction memory is 512 words and data memory 256 words, both read combinationally
// Random programs keep every memory access in the low 256 bytes with base x0
// Each test resets the core and its register file before the program runs

`timescale 1ns/1ps

module rvPipeTb;
    import rvPipePkg::*;

    localparam wordT nop = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam int opAdd = 0;
    localparam int opSub = 1;
    localparam int opAnd = 2;
    localparam int opOr  = 3;
    localparam int opXor = 4;
    localparam int opSlt = 5;
    localparam int watchdogCycles = 6 * (2 * 200 + 20 + 6);

    logic   clk;
    logic   rstInit;
    logic   rerun;
    logic   rst;
    wordT   imemData;
    wordT   dmemRData;
    wordT   imemAddr;
    wordT   dmemAddr;
    wordT   dmemWData;
    logic   dmemWe;
    logic   dmemRe;
    logic   wbValid;
    regIdxT wbRd;
    wordT   wbData;

    wordT   imem [512];
    wordT   dmem [256];
    wordT   expMem [256];
    wordT   prog [$];
    regIdxT expRd [$];
    wordT   expData [$];
    int     expLoads;
    int     seed = 32'hb950_d051;

    tbClock clkGen (
        .clk (clk),
        .rst (rstInit)
    );

    assign rst = rstInit || rerun;

    rvPipeCore uut (
        .clk       (clk),
        .rst       (rst),
        .imemData  (imemData),
        .dmemRData (dmemRData),
        .imemAddr  (imemAddr),
        .dmemAddr  (dmemAddr),
        .dmemWData (dmemWData),
        .dmemWe    (dmemWe),
        .dmemRe    (dmemRe),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData)
    );

    // Fetches past the array read as NOPs
    assign imemData  = (imemAddr[31:11] == '0) ? imem[imemAddr[10:2]] : nop;
    assign dmemRData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWe) begin
            dmem[dmemAddr[9:2]] <= dmemWData;
        end
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic checkWrite(input regIdxT gotRd, input wordT gotData,
                              input regIdxT wantRd, input wordT wantData);
        if (gotRd !== wantRd || gotData !== wantData) begin
            abortRun($sformatf("Fail at %0t: retired x%0d = %h, expected x%0d = %h",
                               $time, gotRd, gotData, wantRd, wantData));
        end
    endtask

    task automatic checkWord(input int idx, input wordT got, input wordT want);
        if (got !== want) begin
            abortRun($sformatf("Fail at %0t: data word %0d is %h, expected %h",
                               $time, idx, got, want));
        end
    endtask

    task automatic matchLoadCount(input int got, input int want);
        if (got != want) begin
            abortRun($sformatf("Fail at %0t: dmemRe was high for %0d cycles, expected %0d",
                               $time, got, want));
        end
    endtask

    function automatic wordT aluRR(input int op, input int rd, input int rs1, input int rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = (op == opSub) ? 7'b0100000 : 7'b0000000;
        case (op)
            opAnd:   f3 = 3'b111;
            opOr:    f3 = 3'b110;
            opXor:   f3 = 3'b100;
            opSlt:   f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic wordT addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic wordT lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic wordT lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic wordT sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // Sequential ISA model, one instruction at a time with no pipeline
    task automatic buildExpected();
        wordT   regs [32];
        wordT   a;
        wordT   b;
        wordT   res;
        wordT   addr;
        wordT   ins;
        logic   writes;
        regIdxT rd;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 256; i++) expMem[i] = '0;
        expRd.delete();
        expData.delete();
        expLoads = 0;
        foreach (prog[k]) begin
            ins    = prog[k];
            rd     = ins[11:7];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            writes = 1'b0;
            res    = '0;
            case (ins[6:0])
                7'b0110011: begin
                    writes = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_111: res = a & b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         writes = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    writes = (ins[14:12] == 3'b000);
                    res    = a + {{20{ins[31]}}, ins[31:20]};
                end
                7'b0110111: begin
                    writes = 1'b1;
                    res    = {ins[31:12], 12'b0};
                end
                7'b0000011: begin
                    writes = (ins[14:12] == 3'b010);
                    addr   = a + {{20{ins[31]}}, ins[31:20]};
                    res    = expMem[addr[9:2]];
                    if (ins[14:12] == 3'b010) begin
                        expLoads++;  // One MEM cycle per LW, x0 target included
                    end
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (ins[14:12] == 3'b010) expMem[addr[9:2]] = b;
                end
                default: writes = 1'b0;  // Bubble
            endcase
            if (writes && rd != '0) begin
                regs[rd] = res;
                expRd.push_back(rd);
                expData.push_back(res);
            end
        end
    endtask

    // Model, memories, then a 4-cycle reset so the core starts clean
    task automatic startProgram();
        buildExpected();
        @(negedge clk);
        rerun = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 512; i++) imem[i] = (i < prog.size()) ? prog[i] : nop;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        repeat (3) @(negedge clk);
        rerun = 1'b0;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        int got;
        int reads;
        startProgram();
        cycles = 0;
        got    = 0;
        reads  = 0;
        // Run until all writes retired and trailing stores had time to land
        while (got < expRd.size() || imemAddr < 4 * (prog.size() + 6)) begin
            @(negedge clk);
            cycles++;
            if (dmemRe) begin
                reads++;
            end
            if (wbValid) begin
                if (got >= expRd.size()) begin
                    abortRun($sformatf("%s: the core retired more writes than expected", name));
                end
                checkWrite(wbRd, wbData, expRd[got], expData[got]);
                got++;
            end
            if (cycles > 2 * prog.size() + 20) begin
                abortRun($sformatf("%s: the program did not finish in time", name));
            end
        end
        matchLoadCount(reads, expLoads);
        for (int i = 0; i < 256; i++) checkWord(i, dmem[i], expMem[i]);
    endtask

    task automatic independentOps();
        prog = '{addi(1, 0, 5), addi(2, 0, -3), lui(3, 32'h12345), addi(4, 0, 100),
                 lui(5, 32'hfffff), nop, nop, nop,
                 aluRR(opAdd, 6, 1, 2), aluRR(opSub, 7, 3, 4), aluRR(opAnd, 8, 3, 5),
                 aluRR(opOr, 9, 1, 4), aluRR(opXor, 10, 2, 5), aluRR(opSlt, 11, 2, 1)};
        runProgram("independent ops");
    endtask

    task automatic dependentChains();
        prog = '{addi(1, 0, 1), aluRR(opAdd, 2, 1, 1), aluRR(opAdd, 3, 2, 1),
                 aluRR(opSub, 4, 3, 2), aluRR(opXor, 5, 4, 3), aluRR(opSlt, 6, 5, 4),
                 aluRR(opOr, 7, 6, 5), addi(7, 7, -9), aluRR(opAnd, 8, 7, 7)};
        runProgram("dependent chains");
    endtask

    task automatic storeThenLoad();
        prog = '{addi(1, 0, 32'h55), addi(2, 0, 16), sw(1, 2, 0), lw(3, 2, 0),
                 aluRR(opAdd, 4, 3, 3), sw(4, 2, 4), lw(5, 2, 4), addi(6, 5, 1),
                 sw(6, 0, 40)};
        runProgram("store then load");
    endtask

    task automatic zeroRegAndIllegal();
        prog = '{addi(0, 0, 9), 32'h0000_007f, 32'hffff_ffff, aluRR(opAdd, 1, 0, 0),
                 addi(2, 0, 3), aluRR(opAdd, 3, 0, 2)};
        runProgram("x0 and unsupported opcode");
    endtask

    task automatic randomProgram();
        int r;
        int pick;
        int rd;
        int rs1;
        int rs2;
        prog.delete();
        for (int i = 0; i < 200; i++) begin
            r    = $random(seed);
            pick = (r & 32'h7fff_ffff) % 10;
            rd   = (r >> 4) & 7;   // Small pool gives many hazards
            rs1  = (r >> 7) & 7;
            rs2  = (r >> 10) & 7;
            if (pick < 6) prog.push_back(aluRR(pick, rd, rs1, rs2));
            else if (pick == 6) prog.push_back(addi(rd, rs1, ((r >> 13) & 12'hfff) - 2048));
            else if (pick == 7) prog.push_back(lui(rd, (r >> 12) & 20'hfffff));
            else if (pick == 8) prog.push_back(lw(rd, 0, ((r >> 13) & 63) * 4));
            else prog.push_back(sw(rs2, 0, ((r >> 13) & 63) * 4));
        end
        runProgram("random program");
    endtask

    // Fetch cycle plus one edge per stage boundary before the retire is visible
    task automatic throughput();
        int edges;
        prog = '{addi(1, 0, 11), addi(2, 0, 22), lui(3, 5), addi(4, 0, -4),
                 addi(5, 0, 55), lui(6, 7), addi(7, 0, 77), addi(8, 0, 88)};
        startProgram();
        edges = 0;
        while (!wbValid) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (edges > 20) abortRun("throughput: no retire pulse after reset release");
        end
        if (edges != 4) begin
            abortRun($sformatf("Fail at %0t: first retire after %0d edges, expected 4",
                               $time, edges));
        end
        foreach (expRd[k]) begin
            if (k > 0) @(negedge clk);
            if (!wbValid) abortRun("throughput: retire stream has a gap");
            checkWrite(wbRd, wbData, expRd[k], expData[k]);
        end
    endtask

    initial begin
        #(watchdogCycles * 100);
        abortRun("Watchdog expired before the tests completed");
    end

    initial begin
        rerun = 1'b0;
        for (int i = 0; i < 512; i++) imem[i] = nop;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        @(negedge rstInit);
        independentOps();
        dependentChains();
        storeThenLoad();
        zeroRegAndIllegal();
        randomProgram();
        throughput();
        $display("Test OK");
        $finish;
    end

endmodule

//--- tests/tbClock.sv
// Clock and power-on reset for the testbench
// 100 ns period, reset high for the first 4 cycles and released on a falling edge

`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- src/rvPipeCore.sv
// Top of the five-stage RV32I subset core
// Instruction and data memory live outside and answer combinationally
// dmemWe is a one-cycle pulse per store, dmemRe a level while a load is in MEM
// wbValid pulses once per retired write to a register other than x0

`timescale 1ns/1ps
`include "rvPipeSettings.svh"

module rvPipeCore (
    input  logic             clk,
    input  logic             rst,
    input  rvPipePkg::wordT  imemData,
    input  rvPipePkg::wordT  dmemRData,
    output rvPipePkg::wordT  imemAddr,
    output rvPipePkg::wordT  dmemAddr,
    output rvPipePkg::wordT  dmemWData,
    output logic             dmemWe,
    output logic             dmemRe,
    output logic             wbValid,
    output rvPipePkg::regIdxT wbRd,
    output rvPipePkg::wordT  wbData
);
    import rvPipePkg::*;

    wordT   pc;
    logic   stall;
    fwdSelT fwdA;
    fwdSelT fwdB;
    ifIdT   ifIdNext;
    idExT   idExNext;
    exMemT  exMemNext;
    memWbT  memWbNext;
    ifIdT   ifId;
    idExT   idEx;
    exMemT  exMem;
    memWbT  memWb;

    // Fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (!stall) begin
            pc <= pc + 4;
        end
    end

    assign imemAddr = pc;

    always_comb begin
        ifIdNext.valid = 1'b1;
        ifIdNext.pc    = pc;
        ifIdNext.instr = imemData;
    end

    pipelineRegisters pipeRegs (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .ifIdNext  (ifIdNext),
        .idExNext  (idExNext),
        .exMemNext (exMemNext),
        .memWbNext (memWbNext),
        .ifId      (ifId),
        .idEx      (idEx),
        .exMem     (exMem),
        .memWb     (memWb)
    );

    decodeStage decode (
        .clk      (clk),
        .rst      (rst),
        .ifId     (ifId),
        .memWb    (memWb),
        .idExNext (idExNext)
    );

    hazardUnit hazards (
        .ifId  (ifId),
        .idEx  (idEx),
        .exMem (exMem),
        .memWb (memWb),
        .stall (stall),
        .fwdA  (fwdA),
        .fwdB  (fwdB)
    );

    executeStage execute (
        .idEx      (idEx),
        .exMem     (exMem),
        .memWb     (memWb),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .exMemNext (exMemNext)
    );

    // MEM stage ports
    assign dmemAddr  = exMem.aluResult;
    assign dmemWData = exMem.storeData;
    assign dmemWe    = exMem.valid && exMem.memWrite;
    assign dmemRe    = exMem.valid && exMem.memRead;

    always_comb begin
        memWbNext.valid    = exMem.valid;
        memWbNext.regWrite = exMem.regWrite;
        memWbNext.rd       = exMem.rd;
        memWbNext.result   = exMem.memRead ? dmemRData : exMem.aluResult;
    end

    // Retire straight from MEM/WB
    assign wbValid = memWb.valid && memWb.regWrite;
    assign wbRd    = memWb.rd;
    assign wbData  = memWb.result;

endmodule

//--- src/executeStage.sv
// Execute stage, forwarding muxes and the ALU
// Loads and stores compute their address with the add operation
// A load in EX/MEM is never a forwarding source, the load-use stall sees to it

`timescale 1ns/1ps

module executeStage (
    input  rvPipePkg::idExT    idEx,
    input  rvPipePkg::exMemT   exMem,
    input  rvPipePkg::memWbT   memWb,
    input  rvPipePkg::fwdSelT  fwdA,
    input  rvPipePkg::fwdSelT  fwdB,
    output rvPipePkg::exMemT   exMemNext
);
    import rvPipePkg::*;

    wordT opA;
    wordT rs2Val;   // Forwarded rs2, also the store data
    wordT opB;
    wordT aluResult;

    function automatic wordT fwdValue(fwdSelT sel, wordT regVal, wordT exMemVal,
                                      wordT memWbVal);
        case (sel)
            fwdExMem: return exMemVal;
            fwdMemWb: return memWbVal;
            default:  return regVal;
        endcase
    endfunction

    assign opA    = fwdValue(fwdA, idEx.rData1, exMem.aluResult, memWb.result);
    assign rs2Val = fwdValue(fwdB, idEx.rData2, exMem.aluResult, memWb.result);
    assign opB    = idEx.aluSrcImm ? idEx.imm : rs2Val;

    always_comb begin
        case (idEx.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluXor:   aluResult = opA ^ opB;
            aluSlt:   aluResult = wordT'($signed(opA) < $signed(opB));
            aluPassB: aluResult = opB;  // LUI
            default:  aluResult = opA + opB;
        endcase
    end

    always_comb begin
        exMemNext.valid     = idEx.valid;
        exMemNext.regWrite  = idEx.regWrite;
        exMemNext.memRead   = idEx.memRead;
        exMemNext.memWrite  = idEx.memWrite;
        exMemNext.rd        = idEx.rd;
        exMemNext.aluResult = aluResult;
        exMemNext.storeData = rs2Val;
    end

endmodule

//--- src/hazardUnit.sv
// Load-use stall detection and forwarding selection
// Only a load in EX followed by a reader in decode stalls, for one cycle
// EX/MEM wins over MEM/WB when both hold the wanted register

`timescale 1ns/1ps

module hazardUnit (
    input  rvPipePkg::ifIdT    ifId,
    input  rvPipePkg::idExT    idEx,
    input  rvPipePkg::exMemT   exMem,
    input  rvPipePkg::memWbT   memWb,
    output logic               stall,
    output rvPipePkg::fwdSelT  fwdA,
    output rvPipePkg::fwdSelT  fwdB
);
    import rvPipePkg::*;

    logic [6:0] opcode;
    logic       readsRs1;
    logic       readsRs2;
    regIdxT     ifRs1;
    regIdxT     ifRs2;

    function automatic fwdSelT pickSource(regIdxT rs, exMemT em, memWbT mw);
        if (rs == '0) return fwdRegFile;
        if (em.valid && em.regWrite && em.rd == rs) return fwdExMem;  // Younger first
        if (mw.valid && mw.regWrite && mw.rd == rs) return fwdMemWb;
        return fwdRegFile;
    endfunction

    // Source usage of the instruction in decode, LUI reads nothing
    assign opcode   = ifId.instr[6:0];
    assign readsRs1 = (opcode == 7'b0110011) || (opcode == 7'b0010011) ||
                      (opcode == 7'b0000011) || (opcode == 7'b0100011);
    assign readsRs2 = (opcode == 7'b0110011) || (opcode == 7'b0100011);
    assign ifRs1    = ifId.instr[19:15];
    assign ifRs2    = ifId.instr[24:20];

    assign stall = ifId.valid && idEx.valid && idEx.memRead && (idEx.rd != '0) &&
                   ((readsRs1 && idEx.rd == ifRs1) || (readsRs2 && idEx.rd == ifRs2));

    assign fwdA = pickSource(idEx.rs1, exMem, memWb);
    assign fwdB = pickSource(idEx.rs2, exMem, memWb);

endmodule

//--- src/decodeStage.sv
// Decode for the supported RV32I subset plus the register file
// Unsupported opcodes and funct codes become invalid items with no effects
// Register file reads are write-first against the MEM/WB write port
// regWrite is cleared for rd == x0 so x0 writes never retire

`timescale 1ns/1ps
`include "rvPipeSettings.svh"

module decodeStage (
    input  logic              clk,
    input  logic              rst,
    input  rvPipePkg::ifIdT   ifId,
    input  rvPipePkg::memWbT  memWb,
    output rvPipePkg::idExT   idExNext
);
    import rvPipePkg::*;

    localparam logic [6:0] opAlu    = 7'b0110011;
    localparam logic [6:0] opAluImm = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    logic       writesRd;
    logic       usesRs1;
    logic       usesRs2;
    logic       isLoad;
    logic       isStore;
    logic       aluSrcImm;
    aluOpT      aluOp;
    wordT       imm;
    regIdxT     rs1;
    regIdxT     rs2;
    regIdxT     rd;
    logic       itemValid;
    logic       wbWrite;
    wordT       regs [`RV_NREGS];

    assign opcode = ifId.instr[6:0];
    assign funct3 = ifId.instr[14:12];
    assign funct7 = ifId.instr[31:25];

    always_comb begin
        supported = 1'b0;
        writesRd  = 1'b0;
        usesRs1   = 1'b0;
        usesRs2   = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        aluSrcImm = 1'b0;
        aluOp     = aluAdd;
        imm       = {{20{ifId.instr[31]}}, ifId.instr[31:20]};  // I format
        case (opcode)
            opAlu: begin
                supported = 1'b1;
                writesRd  = 1'b1;
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: aluOp = aluAdd;
                    {7'b0100000, 3'b000}: aluOp = aluSub;
                    {7'b0000000, 3'b111}: aluOp = aluAnd;
                    {7'b0000000, 3'b110}: aluOp = aluOr;
                    {7'b0000000, 3'b100}: aluOp = aluXor;
                    {7'b0000000, 3'b010}: aluOp = aluSlt;
                    default:              supported = 1'b0;
                endcase
            end
            opAluImm: begin  // ADDI only
                supported = (funct3 == 3'b000);
                writesRd  = 1'b1;
                usesRs1   = 1'b1;
                aluSrcImm = 1'b1;
            end
            opLui: begin
                supported = 1'b1;
                writesRd  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluPassB;
                imm       = {ifId.instr[31:12], 12'b0};
            end
            opLoad: begin  // LW only
                supported = (funct3 == 3'b010);
                writesRd  = 1'b1;
                usesRs1   = 1'b1;
                isLoad    = 1'b1;
                aluSrcImm = 1'b1;
            end
            opStore: begin  // SW only
                supported = (funct3 == 3'b010);
                usesRs1   = 1'b1;
                usesRs2   = 1'b1;
                isStore   = 1'b1;
                aluSrcImm = 1'b1;
                imm       = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
            end
            default: supported = 1'b0;
        endcase
    end

    // Unused source fields read as x0 so they never match a hazard
    assign rs1       = usesRs1 ? ifId.instr[19:15] : '0;
    assign rs2       = usesRs2 ? ifId.instr[24:20] : '0;
    assign rd        = ifId.instr[11:7];
    assign itemValid = ifId.valid && supported;

    assign wbWrite = memWb.valid && memWb.regWrite && (memWb.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[memWb.rd] <= memWb.result;
        end
    end

    always_comb begin
        idExNext.valid     = itemValid;
        idExNext.regWrite  = itemValid && writesRd && (rd != '0);
        idExNext.memRead   = itemValid && isLoad;
        idExNext.memWrite  = itemValid && isStore;
        idExNext.aluSrcImm = aluSrcImm;
        idExNext.aluOp     = aluOp;
        idExNext.rs1       = rs1;
        idExNext.rs2       = rs2;
        idExNext.rd        = rd;
        idExNext.imm       = imm;
        // Write-first bypass from WB
        idExNext.rData1 = (rs1 == '0) ? '0 :
                          (wbWrite && memWb.rd == rs1) ? memWb.result : regs[rs1];
        idExNext.rData2 = (rs2 == '0) ? '0 :
                          (wbWrite && memWb.rd == rs2) ? memWb.result : regs[rs2];
    end

    // rd == x0 must already be filtered out in decode
    assert property (@(posedge clk) disable iff (rst)
        memWb.valid && memWb.regWrite |-> memWb.rd != '0)
        else $error("write to x0 reached MEM/WB");

endmodule

//--- src/pipelineRegisters.sv
// The four stage boundary registers of the pipeline
// stall holds IF/ID and turns the ID/EX entry into a bubble for one cycle
// Reset clears valid and control bits only, payload fields keep old values
// EX/MEM and MEM/WB never stall, there is no back-pressure from outside

`timescale 1ns/1ps

module pipelineRegisters (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  rvPipePkg::ifIdT     ifIdNext,
    input  rvPipePkg::idExT     idExNext,
    input  rvPipePkg::exMemT    exMemNext,
    input  rvPipePkg::memWbT    memWbNext,
    output rvPipePkg::ifIdT     ifId,
    output rvPipePkg::idExT     idEx,
    output rvPipePkg::exMemT    exMem,
    output rvPipePkg::memWbT    memWb
);
    import rvPipePkg::*;

    idExT idExBubble;

    // Same payload, no side effects
    always_comb begin
        idExBubble          = idExNext;
        idExBubble.valid    = 1'b0;
        idExBubble.regWrite = 1'b0;
        idExBubble.memRead  = 1'b0;
        idExBubble.memWrite = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId <= ifIdNext;   // Held while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
        end else if (stall) begin
            idEx <= idExBubble;
        end else begin
            idEx <= idExNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem.valid    <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem <= exMemNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb.valid    <= 1'b0;
            memWb.regWrite <= 1'b0;
        end else begin
            memWb <= memWbNext;
        end
    end

    // Decode and stall bubbles must both arrive without side effects
    assert property (@(posedge clk) disable iff (rst)
        !idEx.valid |-> !idEx.regWrite && !idEx.memWrite)
        else $error("ID/EX bubble carries regWrite or memWrite");

endmodule

//--- src/rvPipePkg.sv
// Types shared by every stage of the five-stage pipeline
// Stage structs are packed and travel whole between stage logic and registers
// Control bits in a struct are only meaningful while valid is set

`include "rvPipeSettings.svh"

package rvPipePkg;

    localparam int regIdxW = $clog2(`RV_NREGS);

    typedef logic [`RV_XLEN-1:0] wordT;  // Data or address word
    typedef logic [regIdxW-1:0]  regIdxT;

    // ALU operations, passB carries the LUI immediate through
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpT;

    // Operand source chosen by the hazard unit
    typedef enum logic [1:0] {
        fwdRegFile,
        fwdExMem,
        fwdMemWb
    } fwdSelT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        logic   regWrite;   // Cleared for rd == x0
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;  // Operand B from imm
        aluOpT  aluOp;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
        wordT   rData1;
        wordT   rData2;
        wordT   imm;
    } idExT;

    typedef struct packed {
        logic   valid;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        regIdxT rd;
        wordT   aluResult;  // Also the data memory address
        wordT   storeData;
    } exMemT;

    typedef struct packed {
        logic   valid;
        logic   regWrite;
        regIdxT rd;
        wordT   result;     // Load data or ALU result
    } memWbT;

endpackage

//--- src/rvPipeSettings.svh
// Core-wide constants for the RV32I pipeline
// Only a 32-bit datapath with 32 registers is supported
// The decoder slices fixed RV32I fields, so changing RV_XLEN or RV_NREGS
// is not a supported configuration

`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
